//--- design/cache_pkg.sv
// cache geometry and shared types

package cache_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTE_W   = 8;
    localparam int LANES    = DATA_W / BYTE_W;   // 4 bytes per word
    localparam int OFFSET_W = 2;
    localparam int SET_W    = 8;
    localparam int SETS     = 1 << SET_W;
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;

    // miss controller state encoding
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE      = 2'd0;
    localparam logic [STATE_W-1:0] ST_WRITEBACK = 2'd1;
    localparam logic [STATE_W-1:0] ST_FETCH     = 2'd2;
    localparam logic [STATE_W-1:0] ST_UPDATE    = 2'd3;

    // one data word, seen whole or as byte lanes
    typedef union packed {
        logic [DATA_W-1:0]             word;
        logic [LANES-1:0][BYTE_W-1:0]  lanes;   // lane 0 is the low byte
    } word_u;

endpackage

//--- design/lookup_if.sv
// lookup and fill signals between controller and store

`timescale 1ns/1ps

interface lookup_if;
    import cache_pkg::*;

    logic               hit;            // valid tag match on an active op
    logic               hit_way;
    logic               victim_way;     // lru choice for replacement
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [DATA_W-1:0]  victim_data;
    logic               fill_en;        // controller in UPDATE

    modport store (
        output hit, hit_way, victim_way, victim_dirty, victim_tag, victim_data,
        input  fill_en
    );

    modport ctrl (
        input  hit, victim_dirty, victim_tag, victim_data,
        output fill_en
    );

endinterface

//--- design/cache_store.sv
// two-way set array with tag compare and lru

`timescale 1ns/1ps

module cache_store (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         rd_en_i,
    input  logic                         wr_en_i,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  cache_pkg::word_u             store_word_i,  // merged hit-write word
    input  cache_pkg::word_u             fill_word_i,   // merged fill word
    lookup_if.store                      lk,
    output cache_pkg::word_u             line_o
);
    import cache_pkg::*;

    logic [TAG_W-1:0] tag;
    logic [SET_W-1:0] set_idx;
    logic             active;
    logic [1:0]       match;

    // per-set state, indexed by way
    logic [1:0]             valid_q [SETS];
    logic [1:0]             dirty_q [SETS];
    logic [1:0][TAG_W-1:0]  tag_q   [SETS];
    word_u [1:0]            data_q  [SETS];
    logic                   lru_q   [SETS];   // points at the way to replace

    assign tag     = addr_i[ADDR_W-1 -: TAG_W];
    assign set_idx = addr_i[OFFSET_W +: SET_W];
    assign active  = rd_en_i || wr_en_i;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
        end
    end

    assign lk.hit     = active && (|match);
    assign lk.hit_way = match[1];   // way 0 unless way 1 matched
    assign line_o     = data_q[set_idx][lk.hit_way];

    // replacement candidate comes straight from the lru bit
    assign lk.victim_way   = lru_q[set_idx];
    assign lk.victim_dirty = valid_q[set_idx][lk.victim_way]
                             && dirty_q[set_idx][lk.victim_way];
    assign lk.victim_tag   = tag_q[set_idx][lk.victim_way];
    assign lk.victim_data  = data_q[set_idx][lk.victim_way].word;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                tag_q[s]   <= '0;
                data_q[s]  <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else if (lk.fill_en) begin
            // refill the victim, write misses land dirty
            valid_q[set_idx][lk.victim_way] <= 1'b1;
            dirty_q[set_idx][lk.victim_way] <= wr_en_i;
            tag_q[set_idx][lk.victim_way]   <= tag;
            data_q[set_idx][lk.victim_way]  <= fill_word_i;
            lru_q[set_idx]                  <= ~lk.victim_way;
        end else if (lk.hit) begin
            lru_q[set_idx] <= ~lk.hit_way;  // other way is now older
            if (wr_en_i) begin
                data_q[set_idx][lk.hit_way]  <= store_word_i;
                dirty_q[set_idx][lk.hit_way] <= 1'b1;
            end
        end
    end

endmodule

//--- design/cache_ctrl.sv
// miss handling state machine

`timescale 1ns/1ps

module cache_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         rd_en_i,
    input  logic                         wr_en_i,
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    lookup_if.ctrl                       lk,
    output logic                         cache_miss_o,
    output logic                         stall_o,
    output logic [cache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                         mem_wr_en_o,
    output logic [cache_pkg::DATA_W-1:0] mem_wdata_o
);
    import cache_pkg::*;

    logic [STATE_W-1:0] state_q;
    logic [STATE_W-1:0] state_d;
    logic               miss;
    logic [SET_W-1:0]   set_idx;

    assign set_idx = addr_i[OFFSET_W +: SET_W];
    assign miss    = (rd_en_i || wr_en_i) && !lk.hit;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = lk.victim_dirty ? ST_WRITEBACK : ST_FETCH;
                end
            end
            ST_WRITEBACK: state_d = ST_FETCH;
            ST_FETCH:     state_d = ST_UPDATE;
            default:      state_d = ST_IDLE;    // UPDATE returns to idle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign lk.fill_en   = (state_q == ST_UPDATE);
    assign cache_miss_o = miss;
    assign stall_o      = (state_q != ST_IDLE) || miss;   // idle stalls only on a miss

    always_comb begin
        mem_addr_o  = addr_i;
        mem_wr_en_o = 1'b0;
        mem_wdata_o = '0;
        case (state_q)
            ST_WRITEBACK: begin
                // victim goes back to its own aligned address
                mem_addr_o  = {lk.victim_tag, set_idx, {OFFSET_W{1'b0}}};
                mem_wr_en_o = 1'b1;
                mem_wdata_o = lk.victim_data;
            end
            ST_FETCH, ST_UPDATE: begin
                mem_addr_o = {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            end
            default: ;
        endcase
    end

endmodule

//--- design/lane_align.sv
// byte lane select and merge

`timescale 1ns/1ps

module lane_align (
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  logic                         word_op_i,
    input  logic                         wr_en_i,
    input  logic [cache_pkg::DATA_W-1:0] wdata_i,
    input  cache_pkg::word_u             line_i,
    input  logic [cache_pkg::DATA_W-1:0] mem_rdata_i,
    input  logic                         fill_i,
    input  logic                         hit_i,
    output cache_pkg::word_u             store_word_o,
    output cache_pkg::word_u             fill_word_o,
    output logic [cache_pkg::DATA_W-1:0] rdata_o
);
    import cache_pkg::*;

    logic [OFFSET_W-1:0] offset;
    word_u               wdata_w;
    word_u               mem_w;
    word_u               src;

    // put the store data into base, whole word or one lane
    function automatic word_u merge(word_u base, word_u data, logic [OFFSET_W-1:0] off,
                                    logic whole);
        word_u res;
        res = base;
        if (whole) begin
            res.word = data.word;
        end else begin
            res.lanes[off] = data.lanes[0];
        end
        return res;
    endfunction

    assign offset  = addr_i[OFFSET_W-1:0];
    assign wdata_w = wdata_i;
    assign mem_w   = mem_rdata_i;

    // memory word wins during a fill, the cached line on a hit
    assign src = fill_i ? mem_w : (hit_i ? line_i : '0);

    assign rdata_o = word_op_i ? src.word : {{(DATA_W-BYTE_W){1'b0}}, src.lanes[offset]};

    assign store_word_o = merge(line_i, wdata_w, offset, word_op_i);
    assign fill_word_o  = wr_en_i ? merge(mem_w, wdata_w, offset, word_op_i) : mem_w;

endmodule

//--- design/cache_top.sv
// write-back data cache top level

`timescale 1ns/1ps

module cache_top (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         rd_en_i,
    input  logic                         wr_en_i,
    input  logic                         word_op_i,   // 1 for word, 0 for byte
    input  logic [cache_pkg::ADDR_W-1:0] addr_i,
    input  logic [cache_pkg::DATA_W-1:0] wdata_i,
    output logic [cache_pkg::DATA_W-1:0] rdata_o,
    output logic                         cache_miss_o,
    output logic                         stall_o,
    output logic [cache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic                         mem_wr_en_o,
    output logic [cache_pkg::DATA_W-1:0] mem_wdata_o,
    input  logic [cache_pkg::DATA_W-1:0] mem_rdata_i
);
    import cache_pkg::*;

    word_u line;         // hit way's word
    word_u store_word;
    word_u fill_word;

    lookup_if lk ();

    cache_store u_store (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rd_en_i      (rd_en_i),
        .wr_en_i      (wr_en_i),
        .addr_i       (addr_i),
        .store_word_i (store_word),
        .fill_word_i  (fill_word),
        .lk           (lk.store),
        .line_o       (line)
    );

    cache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rd_en_i      (rd_en_i),
        .wr_en_i      (wr_en_i),
        .addr_i       (addr_i),
        .lk           (lk.ctrl),
        .cache_miss_o (cache_miss_o),
        .stall_o      (stall_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wr_en_o  (mem_wr_en_o),
        .mem_wdata_o  (mem_wdata_o)
    );

    lane_align u_align (
        .addr_i       (addr_i),
        .word_op_i    (word_op_i),
        .wr_en_i      (wr_en_i),
        .wdata_i      (wdata_i),
        .line_i       (line),
        .mem_rdata_i  (mem_rdata_i),
        .fill_i       (lk.fill_en),
        .hit_i        (lk.hit),
        .store_word_o (store_word),
        .fill_word_o  (fill_word),
        .rdata_o      (rdata_o)
    );

endmodule

//--- testbench/cache_chk.sv
// cache port protocol checks

`timescale 1ns/1ps

module cache_chk (
    input logic clk_i,
    input logic rst_i,
    input logic rd_en_i,
    input logic wr_en_i,
    input logic cache_miss_o,
    input logic stall_o,
    input logic mem_wr_en_o
);
    int unsigned fails = 0;
    logic [2:0]  stall_run_q;   // stall cycles seen so far in this run

    always_ff @(posedge clk_i) begin
        if (rst_i || !stall_o) begin
            stall_run_q <= 3'd0;
        end else if (stall_run_q != 3'd7) begin
            stall_run_q <= stall_run_q + 3'd1;
        end
    end

    // write-back strobe is a single cycle
    wb_single: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_wr_en_o |=> !mem_wr_en_o)
        else begin $error("mem_wr_en_o held longer than one cycle"); fails++; end

    stall_needs_op: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_o |-> (rd_en_i || wr_en_i))
        else begin $error("stall_o high with no active operation"); fails++; end

    // a dirty miss is the longest case at four cycles
    stall_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_o |-> (stall_run_q < 3'd4))
        else begin $error("stall_o run longer than four cycles"); fails++; end

    wb_after_miss: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(mem_wr_en_o) |-> $past(cache_miss_o))
        else begin $error("mem_wr_en_o rose without a preceding miss"); fails++; end

endmodule

//--- testbench/tb_cache_top.sv
// write-back cache testbench

`timescale 1ns/1ps

module tb_cache_top;
    localparam int MEM_WORDS   = 1024;
    localparam int STALL_LIMIT = 8;     // longest miss is four cycles

    logic        clk_i;
    logic        rst_i;
    logic        rd_en_i;
    logic        wr_en_i;
    logic        word_op_i;
    logic [31:0] addr_i;
    logic [31:0] wdata_i;
    logic [31:0] rdata_o;
    logic        cache_miss_o;
    logic        stall_o;
    logic [31:0] mem_addr_o;
    logic        mem_wr_en_o;
    logic [31:0] mem_wdata_o;
    logic [31:0] mem_rdata_i;

    logic [31:0] mem    [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];   // memory contents as the program sees them
    integer      seed;
    int          stalls;
    int          wb_count;
    logic [31:0] wb_addr;
    logic [31:0] wb_data;
    logic        miss_seen;            // cache_miss_o in the first cycle of an op
    logic [31:0] value;
    logic [31:0] base;

    cache_top u_cache_top (.*);

    bind cache_top cache_chk u_chk (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // main memory with combinational read
    assign mem_rdata_i = mem[mem_addr_o[11:2]];

    always @(posedge clk_i) begin
        if (mem_wr_en_o) begin
            mem[mem_addr_o[11:2]] <= mem_wdata_o;
        end
    end

    function automatic logic [31:0] make_addr(int tag, int set, int off);
        return 32'(tag * 1024 + set * 4 + off);
    endfunction

    function automatic logic [31:0] expected_read(logic [31:0] a, logic word);
        logic [31:0] w;
        int          lane;
        w    = shadow[a[11:2]];
        lane = int'(a[1:0]);
        if (word) begin
            return w;
        end
        return {24'h0, w[lane*8 +: 8]};     // byte load is zero-extended
    endfunction

    task automatic shadow_write(input logic [31:0] a, input logic word, input logic [31:0] d);
        int lane;
        lane = int'(a[1:0]);
        if (word) begin
            shadow[a[11:2]] = d;
        end else begin
            shadow[a[11:2]][lane*8 +: 8] = d[7:0];
        end
    endtask

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // one processor operation held until stall_o drops
    task automatic run_op(input logic rd, input logic wr, input logic word,
                          input logic [31:0] a, input logic [31:0] d);
        @(posedge clk_i);
        rd_en_i   <= rd;
        wr_en_i   <= wr;
        word_op_i <= word;
        addr_i    <= a;
        wdata_i   <= d;
        stalls   = 0;
        wb_count = 0;
        @(negedge clk_i);
        miss_seen = cache_miss_o;
        while (stall_o && stalls <= STALL_LIMIT) begin
            if (mem_wr_en_o) begin
                wb_count++;
                wb_addr = mem_addr_o;
                wb_data = mem_wdata_o;
            end
            stalls++;
            @(negedge clk_i);
        end
        if (stall_o) begin
            $display("timeout: stall_o stayed high for %0d cycles", stalls);
            abort_run();
        end else begin
            if (rd) begin
                check_value("rdata_o", rdata_o, expected_read(a, word));
            end
            if (wr) begin
                shadow_write(a, word, d);
            end
            @(posedge clk_i);  // operation completes here
            rd_en_i <= 1'b0;
            wr_en_i <= 1'b0;
        end
    endtask

    initial begin
        seed      = 71883;
        rst_i     = 1'b1;
        rd_en_i   = 1'b0;
        wr_en_i   = 1'b0;
        word_op_i = 1'b1;
        addr_i    = 32'h0;
        wdata_i   = 32'h0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            value = $random(seed);
            mem[i] <= value;
            shadow[i] = value;
        end
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("stall_o", 32'(stall_o), 32'h0);
        check_value("cache_miss_o", 32'(cache_miss_o), 32'h0);
        check_value("mem_wr_en_o", 32'(mem_wr_en_o), 32'h0);
        check_value("rdata_o", rdata_o, 32'h0);

        // cold read then hit
        base = make_addr(0, 5, 0);
        run_op(1'b1, 1'b0, 1'b1, base, 32'h0);
        check_value("cache_miss_o", 32'(miss_seen), 32'h1);
        check_value("stall_o cycles", stalls, 3);
        run_op(1'b1, 1'b0, 1'b1, base, 32'h0);
        check_value("cache_miss_o", 32'(miss_seen), 32'h0);
        check_value("stall_o cycles", stalls, 0);

        // byte stores and loads on a cached word
        base = make_addr(0, 9, 0);
        run_op(1'b1, 1'b0, 1'b1, base, 32'h0);
        for (int off = 0; off < 4; off++) begin
            run_op(1'b0, 1'b1, 1'b0, base + 32'(off), $random(seed));
            check_value("stall_o cycles", stalls, 0);
        end
        for (int off = 0; off < 4; off++) begin
            run_op(1'b1, 1'b0, 1'b0, base + 32'(off), 32'h0);
        end
        run_op(1'b1, 1'b0, 1'b1, base, 32'h0);
        run_op(1'b0, 1'b1, 1'b0, make_addr(1, 12, 2), $random(seed));   // byte store miss
        check_value("stall_o cycles", stalls, 3);
        run_op(1'b1, 1'b0, 1'b1, make_addr(1, 12, 0), 32'h0);
        check_value("stall_o cycles", stalls, 0);

        // lru keeps the recently touched way
        run_op(1'b1, 1'b0, 1'b1, make_addr(0, 20, 0), 32'h0);
        run_op(1'b1, 1'b0, 1'b1, make_addr(1, 20, 0), 32'h0);
        run_op(1'b1, 1'b0, 1'b1, make_addr(0, 20, 0), 32'h0);
        check_value("stall_o cycles", stalls, 0);
        run_op(1'b1, 1'b0, 1'b1, make_addr(2, 20, 0), 32'h0);
        run_op(1'b1, 1'b0, 1'b1, make_addr(0, 20, 0), 32'h0);
        check_value("stall_o cycles", stalls, 0);
        run_op(1'b1, 1'b0, 1'b1, make_addr(1, 20, 0), 32'h0);
        check_value("stall_o cycles", stalls, 3);

        // dirty victim goes back to memory
        base = make_addr(0, 30, 0);
        run_op(1'b0, 1'b1, 1'b1, base, $random(seed));
        run_op(1'b1, 1'b0, 1'b1, make_addr(1, 30, 0), 32'h0);
        check_value("mem_wr_en_o pulses", wb_count, 0);
        run_op(1'b1, 1'b0, 1'b1, make_addr(2, 30, 0), 32'h0);
        check_value("stall_o cycles", stalls, 4);
        check_value("mem_wr_en_o pulses", wb_count, 1);
        check_value("mem_addr_o", wb_addr, base);
        check_value("mem_wdata_o", wb_data, expected_read(base, 1'b1));
        run_op(1'b1, 1'b0, 1'b1, base, 32'h0);
        check_value("stall_o cycles", stalls, 3);

        @(posedge clk_i);
        if (u_cache_top.u_chk.fails != 0) begin
            $display("protocol checker saw %0d assertion failures", u_cache_top.u_chk.fails);
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

//--- cache_sys.f
design/cache_pkg.sv
design/lookup_if.sv
design/cache_store.sv
design/cache_ctrl.sv
design/lane_align.sv
design/cache_top.sv
testbench/cache_chk.sv
testbench/tb_cache_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f cache_sys.f --top-module tb_cache_top -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
